// File: Bender.yml
package:
  name: pu_cfg

sources:
  - design/pu_cfg_pkg.sv
  - design/reg_access_if.sv
  - design/spill_buffer.sv
  - design/axil_write_port.sv
  - design/axil_read_port.sv
  - design/pu_policy_regs.sv
  - design/pu_cfg_top.sv
  - target: test
    files:
      - verification/pu_cfg_assert.sv
      - verification/tb_pu_cfg_top.sv

// File: design/axil_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_read_port #(
  parameter int unsigned NumMemRegions = 2,
  parameter bit          PrivProtOnly  = 1'b0,
  parameter bit          SecuProtOnly  = 1'b0
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 ar_valid_i,
  output logic                                      ar_ready_o,
  input  wire logic [pu_cfg_pkg::AddrWidth-1:0]     ar_addr_i,
  input  wire logic [2:0]                           ar_prot_i,
  output logic                                      r_valid_o,
  input  wire logic                                 r_ready_i,
  output logic [pu_cfg_pkg::RegWidth-1:0]           r_data_o,
  output logic [1:0]                                r_resp_o,
  reg_access_if.reader                              reg_if
);

  localparam int unsigned RegionWidth = (NumMemRegions > 1) ? $clog2(NumMemRegions) : 1;
  // R word is data above the response code
  localparam int unsigned RWidth = pu_cfg_pkg::RegWidth + 2;

  pu_cfg_pkg::reg_target_e ar_target;
  logic                    ar_legal;
  logic [RWidth-1:0]       r_word;
  logic [RWidth-1:0]       r_word_out;

  assign ar_target = pu_cfg_pkg::decode_target(ar_addr_i, NumMemRegions);
  assign ar_legal  = pu_cfg_pkg::prot_ok(ar_prot_i, PrivProtOnly, SecuProtOnly) &&
                     (ar_target != pu_cfg_pkg::target_none);

  // Failed checks select nothing in the storage
  always_comb
  begin
    if (ar_legal)
      reg_if.rd_target = ar_target;
    else
      reg_if.rd_target = pu_cfg_pkg::target_none;
  end

  assign reg_if.rd_region = RegionWidth'(pu_cfg_pkg::region_index(ar_addr_i));

  // Data is sampled into the buffer at acceptance
  assign r_word = ar_legal ? {reg_if.rd_data, pu_cfg_pkg::RespOkay}
                           : {pu_cfg_pkg::ErrorData, pu_cfg_pkg::RespSlvErr};

  spill_buffer #(
    .Width (RWidth)
  ) r_buf_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (ar_valid_i),
    .ready_o (ar_ready_o),
    .data_i  (r_word),
    .valid_o (r_valid_o),
    .ready_i (r_ready_i),
    .data_o  (r_word_out)
  );

  assign r_data_o = r_word_out[RWidth-1:2];
  assign r_resp_o = r_word_out[1:0];

endmodule

`default_nettype wire

// File: design/axil_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_write_port #(
  parameter int unsigned NumMemRegions = 2,
  parameter bit          PrivProtOnly  = 1'b0,
  parameter bit          SecuProtOnly  = 1'b0
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 aw_valid_i,
  output logic                                      aw_ready_o,
  input  wire logic [pu_cfg_pkg::AddrWidth-1:0]     aw_addr_i,
  input  wire logic [2:0]                           aw_prot_i,
  input  wire logic                                 w_valid_i,
  output logic                                      w_ready_o,
  input  wire logic [pu_cfg_pkg::RegWidth-1:0]      w_data_i,
  input  wire logic [pu_cfg_pkg::StrbWidth-1:0]     w_strb_i,
  output logic                                      b_valid_o,
  input  wire logic                                 b_ready_i,
  output logic [1:0]                                b_resp_o,
  reg_access_if.writer                              reg_if
);

  localparam int unsigned RegionWidth = (NumMemRegions > 1) ? $clog2(NumMemRegions) : 1;

  pu_cfg_pkg::reg_target_e aw_target;
  logic                    aw_legal;
  logic                    accept;
  logic                    b_buf_ready;
  logic [1:0]              b_resp;

  // Decode and protection check on the AW address
  assign aw_target = pu_cfg_pkg::decode_target(aw_addr_i, NumMemRegions);
  assign aw_legal  = pu_cfg_pkg::prot_ok(aw_prot_i, PrivProtOnly, SecuProtOnly) &&
                     (aw_target != pu_cfg_pkg::target_none);

  // AW and W are taken together, only when the B buffer has room
  assign accept     = aw_valid_i & w_valid_i & b_buf_ready;
  assign aw_ready_o = accept;
  assign w_ready_o  = accept;

  always_comb
  begin
    reg_if.wr_ctrl_be   = '0;
    reg_if.wr_policy_be = '0;
    // Illegal writes leave the enables low
    if (accept && aw_legal)
    begin
      if (aw_target == pu_cfg_pkg::target_ctrl)
        reg_if.wr_ctrl_be = w_strb_i;
      else
        reg_if.wr_policy_be = w_strb_i;
    end
  end

  assign reg_if.wr_region = RegionWidth'(pu_cfg_pkg::region_index(aw_addr_i));
  assign reg_if.wr_data   = w_data_i;

  assign b_resp = aw_legal ? pu_cfg_pkg::RespOkay : pu_cfg_pkg::RespSlvErr;

  // B response register stage
  spill_buffer #(
    .Width (2)
  ) b_buf_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (accept),
    .ready_o (b_buf_ready),
    .data_i  (b_resp),
    .valid_o (b_valid_o),
    .ready_i (b_ready_i),
    .data_o  (b_resp_o)
  );

endmodule

`default_nettype wire

// File: design/pu_cfg_pkg.sv
`default_nettype none

package pu_cfg_pkg;

  // Bus and register geometry
  localparam int unsigned RegWidth  = 32;
  localparam int unsigned StrbWidth = RegWidth / 8;
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned AddrLsb   = 2;

  // Region index bits inside the policy window
  localparam int unsigned MaxRegionBits = AddrWidth - AddrLsb - 1;

  // Register map
  localparam logic [AddrWidth-1:0] CtrlAddr   = 7'h00;
  localparam logic [AddrWidth-1:0] PolicyBase = 7'h40;

  // Two bits per domain fill one 32-bit word
  localparam int unsigned MaxDomains = 16;

  // AXI response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // Filler returned on a failed read
  localparam logic [RegWidth-1:0] ErrorData = 32'hBA5E_1E55;

  typedef enum logic [1:0] {
    target_none,
    target_ctrl,
    target_policy
  } reg_target_e;

  // Bit 1 grants write, bit 0 grants read
  typedef struct packed {
    logic write;
    logic read;
  } policy_entry_t;

  // Per-domain view for masking and policy_o, byte view for strobes
  typedef union packed {
    policy_entry_t [MaxDomains-1:0] entries;
    logic [StrbWidth-1:0][7:0]      bytes;
  } policy_word_u;

  // Privileged is prot[0] high, secure is prot[1] low
  function automatic logic prot_ok(logic [2:0] prot, logic priv_only, logic secu_only);
    return (~priv_only | prot[0]) & (~secu_only | ~prot[1]);
  endfunction

  // Word-granular decode, the low address bits are ignored
  function automatic reg_target_e decode_target(logic [AddrWidth-1:0] addr,
                                                int unsigned num_regions);
    int unsigned word_idx;
    int unsigned base_idx;
    word_idx = 32'(addr[AddrWidth-1:AddrLsb]);
    base_idx = 32'(PolicyBase[AddrWidth-1:AddrLsb]);
    if (word_idx == 32'(CtrlAddr[AddrWidth-1:AddrLsb]))
      return target_ctrl;
    if ((word_idx >= base_idx) && (word_idx < base_idx + num_regions))
      return target_policy;
    return target_none;
  endfunction

  // Region number relative to the first policy word
  function automatic logic [MaxRegionBits-1:0] region_index(logic [AddrWidth-1:0] addr);
    return addr[AddrLsb +: MaxRegionBits] - PolicyBase[AddrLsb +: MaxRegionBits];
  endfunction

endpackage

`default_nettype wire

// File: design/pu_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module pu_cfg_top #(
  parameter int unsigned NumMemRegions = 2,
  parameter int unsigned NumDomains    = 2,
  parameter bit          PrivProtOnly  = 1'b0,
  parameter bit          SecuProtOnly  = 1'b0
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  // Write address channel
  input  wire logic                                 aw_valid_i,
  output logic                                      aw_ready_o,
  input  wire logic [pu_cfg_pkg::AddrWidth-1:0]     aw_addr_i,
  input  wire logic [2:0]                           aw_prot_i,
  // Write data channel
  input  wire logic                                 w_valid_i,
  output logic                                      w_ready_o,
  input  wire logic [pu_cfg_pkg::RegWidth-1:0]      w_data_i,
  input  wire logic [pu_cfg_pkg::StrbWidth-1:0]     w_strb_i,
  // Write response channel
  output logic                                      b_valid_o,
  input  wire logic                                 b_ready_i,
  output logic [1:0]                                b_resp_o,
  // Read address channel
  input  wire logic                                 ar_valid_i,
  output logic                                      ar_ready_o,
  input  wire logic [pu_cfg_pkg::AddrWidth-1:0]     ar_addr_i,
  input  wire logic [2:0]                           ar_prot_i,
  // Read data channel
  output logic                                      r_valid_o,
  input  wire logic                                 r_ready_i,
  output logic [pu_cfg_pkg::RegWidth-1:0]           r_data_o,
  output logic [1:0]                                r_resp_o,
  // Policy bits per region and domain
  output logic [NumMemRegions*NumDomains*2-1:0]     policy_o
);

  // Shared link between both channel ports and the storage
  reg_access_if #(
    .NumMemRegions (NumMemRegions)
  ) reg_if ();

  axil_write_port #(
    .NumMemRegions (NumMemRegions),
    .PrivProtOnly  (PrivProtOnly),
    .SecuProtOnly  (SecuProtOnly)
  ) write_port_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_prot_i  (aw_prot_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .reg_if     (reg_if.writer)
  );

  axil_read_port #(
    .NumMemRegions (NumMemRegions),
    .PrivProtOnly  (PrivProtOnly),
    .SecuProtOnly  (SecuProtOnly)
  ) read_port_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_prot_i  (ar_prot_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .reg_if     (reg_if.reader)
  );

  // Register storage, protection settings stay in the ports
  pu_policy_regs #(
    .NumMemRegions (NumMemRegions),
    .NumDomains    (NumDomains)
  ) policy_regs_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .reg_if   (reg_if.storage),
    .policy_o (policy_o)
  );

endmodule

`default_nettype wire

// File: design/pu_policy_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pu_policy_regs #(
  parameter int unsigned NumMemRegions = 2,
  parameter int unsigned NumDomains    = 2
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  reg_access_if.storage                             reg_if,
  output logic [NumMemRegions*NumDomains*2-1:0]     policy_o
);

  // Control word, byte addressable
  logic [pu_cfg_pkg::StrbWidth-1:0][7:0]           ctrl_q;
  // One policy word per memory region
  pu_cfg_pkg::policy_word_u [NumMemRegions-1:0]    policy_q;
  // Incoming policy data with unused domains cleared
  pu_cfg_pkg::policy_word_u                        wr_word;

  always_comb
  begin
    wr_word = reg_if.wr_data;
    for (int d = 0; d < pu_cfg_pkg::MaxDomains; d++)
    begin
      // Domains beyond NumDomains always read back zero
      if (d >= NumDomains)
        wr_word.entries[d] = '0;
    end
  end

  // Byte lanes update only where the strobe enables them
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ctrl_q   <= '0;
      policy_q <= '0;
    end
    else
    begin
      for (int b = 0; b < pu_cfg_pkg::StrbWidth; b++)
      begin
        if (reg_if.wr_ctrl_be[b])
          ctrl_q[b] <= reg_if.wr_data[8*b +: 8];
        if (reg_if.wr_policy_be[b])
          policy_q[reg_if.wr_region].bytes[b] <= wr_word.bytes[b];
      end
    end
  end

  // Read multiplexer, combinational
  always_comb
  begin
    case (reg_if.rd_target)
      pu_cfg_pkg::target_ctrl:
        reg_if.rd_data = ctrl_q;
      pu_cfg_pkg::target_policy:
        reg_if.rd_data = policy_q[reg_if.rd_region];
      default:
        reg_if.rd_data = '0;
    endcase
  end

  // Flatten region-major, write bit above read bit
  for (genvar r = 0; r < NumMemRegions; r++)
  begin : gen_region
    for (genvar d = 0; d < NumDomains; d++)
    begin : gen_domain
      assign policy_o[(r*NumDomains+d)*2 +: 2] = policy_q[r].entries[d];
    end
  end

endmodule

`default_nettype wire

// File: design/reg_access_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if #(
  parameter int unsigned NumMemRegions = 2
);

  localparam int unsigned RegionWidth = (NumMemRegions > 1) ? $clog2(NumMemRegions) : 1;

  // Write side, one-cycle byte enable pulses
  logic [pu_cfg_pkg::StrbWidth-1:0] wr_ctrl_be;
  logic [pu_cfg_pkg::StrbWidth-1:0] wr_policy_be;
  logic [RegionWidth-1:0]           wr_region;
  logic [pu_cfg_pkg::RegWidth-1:0]  wr_data;

  // Read side, data returns in the same cycle
  pu_cfg_pkg::reg_target_e          rd_target;
  logic [RegionWidth-1:0]           rd_region;
  logic [pu_cfg_pkg::RegWidth-1:0]  rd_data;

  modport writer (
    output wr_ctrl_be, wr_policy_be, wr_region, wr_data
  );

  modport reader (
    output rd_target, rd_region,
    input  rd_data
  );

  modport storage (
    input  wr_ctrl_be, wr_policy_be, wr_region, wr_data,
    input  rd_target, rd_region,
    output rd_data
  );

endinterface

`default_nettype wire

// File: design/spill_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module spill_buffer #(
  parameter int unsigned Width = 2
) (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  input  wire logic             valid_i,
  output logic                  ready_o,
  input  wire logic [Width-1:0] data_i,
  output logic                  valid_o,
  input  wire logic             ready_i,
  output logic [Width-1:0]      data_o
);

  // Slot a takes new items, slot b holds the older one when stalled
  logic             a_full_q;
  logic             b_full_q;
  logic [Width-1:0] a_data_q;
  logic [Width-1:0] b_data_q;
  logic             a_fill;
  logic             a_drain;
  logic             b_fill;
  logic             b_drain;

  assign a_fill  = valid_i & ready_o;
  // Slot a empties whenever b is free
  assign a_drain = a_full_q & ~b_full_q;
  // Stalled output moves a into b
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end
    else
    begin
      a_full_q <= a_fill | (a_full_q & ~a_drain);
      b_full_q <= b_fill | (b_full_q & ~b_drain);
    end
  end

  // Payload slots
  always_ff @(posedge clk_i)
  begin
    if (a_fill)
      a_data_q <= data_i;
    if (b_fill)
      b_data_q <= a_data_q;
  end

  // Ready depends on state only, so no input-to-output path
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  // Older item lives in b
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// File: pu_cfg.f
design/pu_cfg_pkg.sv
design/reg_access_if.sv
design/spill_buffer.sv
design/axil_write_port.sv
design/axil_read_port.sv
design/pu_policy_regs.sv
design/pu_cfg_top.sv
verification/pu_cfg_assert.sv
verification/tb_pu_cfg_top.sv

// File: verification/pu_cfg_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pu_cfg_assert (
  input wire logic        clk_i,
  input wire logic        rst_n_i,
  input wire logic        aw_ready_o,
  input wire logic        w_ready_o,
  input wire logic        b_valid_o,
  input wire logic        b_ready_i,
  input wire logic [1:0]  b_resp_o,
  input wire logic        r_valid_o,
  input wire logic        r_ready_i,
  input wire logic [31:0] r_data_o,
  input wire logic [1:0]  r_resp_o
);

  // Stalled B response keeps valid and payload
  b_hold_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else $error("B response dropped or changed while stalled");

  // Stalled R response keeps valid and payload
  r_hold_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
    else $error("R response dropped or changed while stalled");

  // AW and W are always accepted together
  ready_pair_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_ready_o == w_ready_o)
    else $error("aw_ready_o and w_ready_o differ");

  // Reset clears both response buffers
  reset_check: assert property (@(posedge clk_i)
    !rst_n_i |=> !b_valid_o && !r_valid_o)
    else $error("Response valid high during reset");

endmodule

bind pu_cfg_top pu_cfg_assert assert_inst (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .aw_ready_o (aw_ready_o),
  .w_ready_o  (w_ready_o),
  .b_valid_o  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_resp_o   (b_resp_o),
  .r_valid_o  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_data_o   (r_data_o),
  .r_resp_o   (r_resp_o)
);

`default_nettype wire

// File: verification/tb_pu_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pu_cfg_top;

  localparam int unsigned NumMemRegions = 4;
  localparam int unsigned NumDomains    = 6;
  localparam int unsigned PolicyWidth   = NumMemRegions * NumDomains * 2;
  localparam int unsigned NumRows       = 23;
  localparam int unsigned ResetCycles   = 4;
  localparam int unsigned HalfPeriod    = 20;

  localparam bit         OpWrite = 1'b0;
  localparam bit         OpRead  = 1'b1;
  localparam logic [1:0] Okay    = 2'b00;
  localparam logic [1:0] SlvErr  = 2'b10;
  localparam logic [31:0] Filler = 32'hBA5E_1E55;

  // One bus operation and everything expected from it
  typedef struct packed {
    bit                     is_read;
    logic [6:0]             addr;
    logic [31:0]            data;
    logic [3:0]             strb;
    logic [2:0]             prot;
    logic [1:0]             resp;
    logic [31:0]            rdata;
    logic [PolicyWidth-1:0] policy;
  } op_t;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   aw_valid_i;
  logic                   aw_ready_o;
  logic [6:0]             aw_addr_i;
  logic [2:0]             aw_prot_i;
  logic                   w_valid_i;
  logic                   w_ready_o;
  logic [31:0]            w_data_i;
  logic [3:0]             w_strb_i;
  logic                   b_valid_o;
  logic                   b_ready_i;
  logic [1:0]             b_resp_o;
  logic                   ar_valid_i;
  logic                   ar_ready_o;
  logic [6:0]             ar_addr_i;
  logic [2:0]             ar_prot_i;
  logic                   r_valid_o;
  logic                   r_ready_i;
  logic [31:0]            r_data_o;
  logic [1:0]             r_resp_o;
  logic [PolicyWidth-1:0] policy_o;

  op_t         rows [NumRows];
  int unsigned fill_idx;
  int unsigned errors;
  int unsigned failed_rows;
  int unsigned b_count;
  int unsigned r_count;
  int unsigned exp_b_count;
  int unsigned exp_r_count;
  logic [31:0] lfsr;

  pu_cfg_top #(
    .NumMemRegions (NumMemRegions),
    .NumDomains    (NumDomains),
    .PrivProtOnly  (1'b1),
    .SecuProtOnly  (1'b0)
  ) pu_cfg_top_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_prot_i  (aw_prot_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_prot_i  (ar_prot_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .policy_o   (policy_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(HalfPeriod) clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic add_row(input bit is_read, input logic [6:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [2:0] prot, input logic [1:0] resp,
                         input logic [31:0] rdata, input logic [PolicyWidth-1:0] policy);
    rows[fill_idx] = '{is_read, addr, data, strb, prot, resp, rdata, policy};
    fill_idx++;
  endtask

  // Policy words hold 6 domains, region r sits at policy_o[12r +: 12]
  task automatic load_table();
    // Full write and readback of the control word
    add_row(OpWrite, 7'h00, 32'hA5A5_0F0F, 4'hF, 3'b001, Okay, 32'h0, 48'h0);
    add_row(OpRead,  7'h00, 32'h0, 4'h0, 3'b001, Okay, 32'hA5A5_0F0F, 48'h0);
    // Byte 2 only
    add_row(OpWrite, 7'h00, 32'h1234_5678, 4'h4, 3'b001, Okay, 32'h0, 48'h0);
    add_row(OpRead,  7'h00, 32'h0, 4'h0, 3'b001, Okay, 32'hA534_0F0F, 48'h0);
    // Region 2 keeps only the low 12 bits
    add_row(OpWrite, 7'h48, 32'hFFFF_FFFF, 4'hF, 3'b001, Okay, 32'h0, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h48, 32'h0, 4'h0, 3'b001, Okay, 32'h0000_0FFF, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h44, 32'h0, 4'h0, 3'b001, Okay, 32'h0, 48'h000F_FF00_0000);
    // Unprivileged accesses are refused
    add_row(OpWrite, 7'h44, 32'h0000_0555, 4'hF, 3'b000, SlvErr, 32'h0, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h44, 32'h0, 4'h0, 3'b000, SlvErr, Filler, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h44, 32'h0, 4'h0, 3'b001, Okay, 32'h0, 48'h000F_FF00_0000);
    add_row(OpWrite, 7'h00, 32'hFFFF_FFFF, 4'hF, 3'b000, SlvErr, 32'h0, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h00, 32'h0, 4'h0, 3'b001, Okay, 32'hA534_0F0F, 48'h000F_FF00_0000);
    // Unmapped words, 0x50 is region 4
    add_row(OpWrite, 7'h04, 32'h0000_0001, 4'hF, 3'b001, SlvErr, 32'h0, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h04, 32'h0, 4'h0, 3'b001, SlvErr, Filler, 48'h000F_FF00_0000);
    add_row(OpWrite, 7'h10, 32'hFFFF_FFFF, 4'hF, 3'b001, SlvErr, 32'h0, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h10, 32'h0, 4'h0, 3'b001, SlvErr, Filler, 48'h000F_FF00_0000);
    add_row(OpWrite, 7'h50, 32'hFFFF_FFFF, 4'hF, 3'b001, SlvErr, 32'h0, 48'h000F_FF00_0000);
    add_row(OpRead,  7'h50, 32'h0, 4'h0, 3'b001, SlvErr, Filler, 48'h000F_FF00_0000);
    // Strobed policy writes with masking
    add_row(OpWrite, 7'h4C, 32'h0000_0123, 4'h1, 3'b001, Okay, 32'h0, 48'h023F_FF00_0000);
    add_row(OpRead,  7'h4C, 32'h0, 4'h0, 3'b001, Okay, 32'h0000_0023, 48'h023F_FF00_0000);
    add_row(OpWrite, 7'h40, 32'hFFFF_FAAA, 4'h3, 3'b001, Okay, 32'h0, 48'h023F_FF00_0AAA);
    add_row(OpRead,  7'h40, 32'h0, 4'h0, 3'b001, Okay, 32'h0000_0AAA, 48'h023F_FF00_0AAA);
    add_row(OpRead,  7'h00, 32'h0, 4'h0, 3'b011, Okay, 32'hA534_0F0F, 48'h023F_FF00_0AAA);
  endtask

  task automatic run_write(input int unsigned idx);
    op_t        op;
    logic [1:0] resp;
    op = rows[idx];
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= op.addr;
    aw_prot_i  <= op.prot;
    w_valid_i  <= 1'b1;
    w_data_i   <= op.data;
    w_strb_i   <= op.strb;
    // AW and W go in together once the B buffer has room
    do
      @(negedge clk_i);
    while (!aw_ready_o);
    if (w_ready_o !== 1'b1)
    begin
      $display("FAILED row %0d w_ready_o: got 0x%h expected 0x1", idx, w_ready_o);
      errors++;
    end
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    do
      @(negedge clk_i);
    while (!(b_valid_o && b_ready_i));
    resp = b_resp_o;
    if (resp !== op.resp)
    begin
      $display("FAILED row %0d b_resp_o: got 0x%h expected 0x%h", idx, resp, op.resp);
      errors++;
    end
    if (policy_o !== op.policy)
    begin
      $display("FAILED row %0d policy_o: got 0x%h expected 0x%h", idx, policy_o, op.policy);
      errors++;
    end
  endtask

  task automatic run_read(input int unsigned idx);
    op_t         op;
    logic [1:0]  resp;
    logic [31:0] data;
    op = rows[idx];
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= op.addr;
    ar_prot_i  <= op.prot;
    do
      @(negedge clk_i);
    while (!ar_ready_o);
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    do
      @(negedge clk_i);
    while (!(r_valid_o && r_ready_i));
    resp = r_resp_o;
    data = r_data_o;
    if (resp !== op.resp)
    begin
      $display("FAILED row %0d r_resp_o: got 0x%h expected 0x%h", idx, resp, op.resp);
      errors++;
    end
    if (data !== op.rdata)
    begin
      $display("FAILED row %0d r_data_o: got 0x%h expected 0x%h", idx, data, op.rdata);
      errors++;
    end
    if (policy_o !== op.policy)
    begin
      $display("FAILED row %0d policy_o: got 0x%h expected 0x%h", idx, policy_o, op.policy);
      errors++;
    end
  endtask

  // Random back-pressure, two LFSR steps per cycle
  always @(posedge clk_i)
  begin
    lfsr = lfsr_step(lfsr);
    b_ready_i <= lfsr[0];
    lfsr = lfsr_step(lfsr);
    r_ready_i <= lfsr[0];
  end

  // Counts every completed response, extra ones included
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (b_valid_o && b_ready_i)
        b_count++;
      if (r_valid_o && r_ready_i)
        r_count++;
    end
  end

  initial
  begin
    repeat (ResetCycles + NumRows * 20) @(posedge clk_i);
    $display("Timeout after %0d cycles, a response never arrived", ResetCycles + NumRows * 20);
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    int unsigned err_before;
    rst_n_i     = 1'b0;
    aw_valid_i  = 1'b0;
    aw_addr_i   = '0;
    aw_prot_i   = '0;
    w_valid_i   = 1'b0;
    w_data_i    = '0;
    w_strb_i    = '0;
    b_ready_i   = 1'b0;
    ar_valid_i  = 1'b0;
    ar_addr_i   = '0;
    ar_prot_i   = '0;
    r_ready_i   = 1'b0;
    lfsr        = 32'h388a_8bbd;
    fill_idx    = 0;
    errors      = 0;
    failed_rows = 0;
    b_count     = 0;
    r_count     = 0;
    exp_b_count = 0;
    exp_r_count = 0;
    load_table();
    repeat (ResetCycles) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int unsigned i = 0; i < NumRows; i++)
    begin
      err_before = errors;
      if (rows[i].is_read)
      begin
        run_read(i);
        exp_r_count++;
      end
      else
      begin
        run_write(i);
        exp_b_count++;
      end
      if (errors != err_before)
        failed_rows++;
      $display("row %0d %s 0x%02h: %s", i, rows[i].is_read ? "read" : "write", rows[i].addr,
               (errors == err_before) ? "ok" : "mismatch");
    end
    // Idle cycles let a duplicate response show up in the counts
    repeat (4) @(posedge clk_i);
    if (b_count != exp_b_count)
    begin
      $display("Wrong number of write responses, %0d seen and %0d expected", b_count, exp_b_count);
      errors++;
    end
    if (r_count != exp_r_count)
    begin
      $display("Wrong number of read responses, %0d seen and %0d expected", r_count, exp_r_count);
      errors++;
    end
    $display("rows %0d, rows with errors %0d, errors %0d", NumRows, failed_rows, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
